// ==== Bender.yml ====
package:
  name: systolic_gemm

sources:
  - files:
      - rtl/gemm_pkg.sv
      - rtl/pe_cell.sv
      - rtl/pe_array.sv
      - rtl/operand_buffer.sv
      - rtl/result_buffer.sv
      - rtl/gemm_ctrl.sv
      - rtl/systolic_gemm.sv
  - target: test
    files:
      - test/tb_clock.sv
      - test/tb_checker.sv
      - test/tb_systolic_gemm.sv

// ==== all.f ====
rtl/gemm_pkg.sv
rtl/pe_cell.sv
rtl/pe_array.sv
rtl/operand_buffer.sv
rtl/result_buffer.sv
rtl/gemm_ctrl.sv
rtl/systolic_gemm.sv
test/tb_clock.sv
test/tb_checker.sv
test/tb_systolic_gemm.sv

// ==== rtl/gemm_ctrl.sv ====
// Controller FSM: clear, stream, drain, capture and done sequencing
`timescale 1ns/10ps
`default_nettype none

module gemm_ctrl import gemm_pkg::*; (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       start,
    output logic       busy,
    output logic       done,
    output logic       clear,
    output logic       feed_en,
    output logic [3:0] step,
    output logic       capture
);

    ctrl_state_t state;
    ctrl_state_t state_nxt;
    logic [3:0]  cnt;
    logic [3:0]  cnt_nxt;
    logic        cnt_last;

    // One counter serves both the stream and the drain phase
    always_comb begin
        case (state)
            STREAM:  cnt_last = (cnt == 4'(STREAM_CYCLES - 1));
            DRAIN:   cnt_last = (cnt == 4'(DRAIN_CYCLES - 1));
            default: cnt_last = 1'b0;
        endcase
    end

    always_comb begin
        state_nxt = state;
        cnt_nxt   = cnt;
        case (state)
            IDLE: begin
                // start is ignored anywhere else
                if (start) begin
                    state_nxt = CLEAR;
                end
            end
            CLEAR: begin
                state_nxt = STREAM;
                cnt_nxt   = '0;
            end
            STREAM: begin
                if (cnt_last) begin
                    state_nxt = DRAIN;
                    cnt_nxt   = '0;
                end else begin
                    cnt_nxt = cnt + 4'd1;
                end
            end
            DRAIN: begin
                if (cnt_last) begin
                    state_nxt = DONE;
                    cnt_nxt   = '0;
                end else begin
                    cnt_nxt = cnt + 4'd1;
                end
            end
            DONE: begin
                state_nxt = IDLE;
            end
            default: begin
                state_nxt = IDLE;
                cnt_nxt   = '0;
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= IDLE;
            cnt   <= '0;
        end else begin
            state <= state_nxt;
            cnt   <= cnt_nxt;
        end
    end

    // Strobes straight from the state
    assign busy    = (state != IDLE);
    assign clear   = (state == CLEAR);
    assign feed_en = (state == STREAM);
    assign done    = (state == DONE);
    assign capture = (state == DONE);
    assign step    = cnt;

endmodule

`default_nettype wire

// ==== rtl/gemm_pkg.sv ====
// Sizes, element types, write and feed structs, controller states for the systolic GEMM
`default_nettype none

package gemm_pkg;

    // Array geometry
    localparam int ARRAY_SIZE = 4;
    localparam int DATA_WIDTH = 16;
    localparam int ACC_WIDTH  = 32;
    localparam int IDX_WIDTH  = 2;

    // Schedule lengths
    localparam int STREAM_CYCLES = ARRAY_SIZE + 2 * (ARRAY_SIZE - 1);
    localparam int DRAIN_CYCLES  = 2;

    typedef logic signed [DATA_WIDTH-1:0] operand_t;
    typedef logic signed [ACC_WIDTH-1:0]  acc_t;

    // Single-cycle operand write strobe
    // lane is the row of A or the column of B, pos is the inner index k
    typedef struct packed {
        logic                 en;
        logic [IDX_WIDTH-1:0] lane;
        logic [IDX_WIDTH-1:0] pos;
        operand_t             data;
    } operand_wr_t;

    // One element per lane, lane 0 in the low bits
    typedef operand_t [ARRAY_SIZE-1:0] lane_feed_t;

    // Entry index is row * ARRAY_SIZE + col
    typedef acc_t [ARRAY_SIZE*ARRAY_SIZE-1:0] acc_grid_t;

    typedef enum logic [2:0] {
        IDLE,
        CLEAR,
        STREAM,
        DRAIN,
        DONE
    } ctrl_state_t;

endpackage

`default_nettype wire

// ==== rtl/operand_buffer.sv ====
// Operand store with skewed, registered lane outputs for the array edge
`timescale 1ns/10ps
`default_nettype none

module operand_buffer import gemm_pkg::*; (
    input  logic        clk,
    input  logic        rst_n,
    input  operand_wr_t wr,
    input  logic        feed_en,
    input  logic [3:0]  step,
    output lane_feed_t  feed
);

    // Indexed by lane, then inner position
    operand_t mem [ARRAY_SIZE][ARRAY_SIZE];
    operand_t lane_nxt [ARRAY_SIZE];

    // Host writes, old value wins on a same-cycle read
    always_ff @(posedge clk) begin
        if (wr.en) begin
            mem[wr.lane][wr.pos] <= wr.data;
        end
    end

    // Lane i lags by i steps to form the systolic wavefront
    always_comb begin
        for (int i = 0; i < ARRAY_SIZE; i++) begin
            lane_nxt[i] = '0;
            if (feed_en && (int'(step) >= i) && (int'(step) < i + ARRAY_SIZE)) begin
                lane_nxt[i] = mem[i][IDX_WIDTH'(int'(step) - i)];
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            feed <= '0;
        end else begin
            for (int i = 0; i < ARRAY_SIZE; i++) begin
                feed[i] <= lane_nxt[i];
            end
        end
    end

endmodule

`default_nettype wire

// ==== rtl/pe_array.sv ====
// 4x4 grid of PE cells with edge feeding and packed accumulator output
`timescale 1ns/10ps
`default_nettype none

module pe_array import gemm_pkg::*; (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       clear,
    input  lane_feed_t a_feed,
    input  lane_feed_t b_feed,
    output acc_grid_t  acc
);

    operand_t a_q      [ARRAY_SIZE][ARRAY_SIZE];
    operand_t b_q      [ARRAY_SIZE][ARRAY_SIZE];
    acc_t     cell_acc [ARRAY_SIZE][ARRAY_SIZE];

    for (genvar r = 0; r < ARRAY_SIZE; r++) begin : g_row
        for (genvar c = 0; c < ARRAY_SIZE; c++) begin : g_col
            operand_t a_in;
            operand_t b_in;

            // A enters from the left, B from the top
            if (c == 0) begin : g_a_edge
                assign a_in = a_feed[r];
            end else begin : g_a_link
                assign a_in = a_q[r][c-1];
            end

            if (r == 0) begin : g_b_edge
                assign b_in = b_feed[c];
            end else begin : g_b_link
                assign b_in = b_q[r-1][c];
            end

            pe_cell u_pe (
                .clk   (clk),
                .rst_n (rst_n),
                .clear (clear),
                .a_in  (a_in),
                .b_in  (b_in),
                .a_out (a_q[r][c]),
                .b_out (b_q[r][c]),
                .acc   (cell_acc[r][c])
            );
        end
    end

    // Row-major packing
    always_comb begin
        for (int r = 0; r < ARRAY_SIZE; r++) begin
            for (int c = 0; c < ARRAY_SIZE; c++) begin
                acc[r*ARRAY_SIZE + c] = cell_acc[r][c];
            end
        end
    end

endmodule

`default_nettype wire

// ==== rtl/pe_cell.sv ====
// Processing element: signed multiply-accumulate with operand pass-through
`timescale 1ns/10ps
`default_nettype none

module pe_cell import gemm_pkg::*; (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     clear,
    input  operand_t a_in,
    input  operand_t b_in,
    output operand_t a_out,
    output operand_t b_out,
    output acc_t     acc
);

    acc_t prod;

    // Full-width signed product, accumulator wraps at 32 bits
    assign prod = a_in * b_in;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            a_out <= '0;
            b_out <= '0;
            acc   <= '0;
        end else if (clear) begin
            a_out <= '0;
            b_out <= '0;
            acc   <= '0;
        end else begin
            // One cycle per hop to the right and down
            a_out <= a_in;
            b_out <= b_in;
            acc   <= acc + prod;
        end
    end

endmodule

`default_nettype wire

// ==== rtl/result_buffer.sv ====
// Result store: whole-grid capture and combinational host read
`timescale 1ns/10ps
`default_nettype none

module result_buffer import gemm_pkg::*; (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 capture,
    input  acc_grid_t            acc,
    input  logic [IDX_WIDTH-1:0] rd_row,
    input  logic [IDX_WIDTH-1:0] rd_col,
    output acc_t                 rd_data
);

    acc_grid_t grid_q;

    // Held until the next run captures
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            grid_q <= '0;
        end else if (capture) begin
            grid_q <= acc;
        end
    end

    // {row, col} is the row-major entry index
    assign rd_data = grid_q[{rd_row, rd_col}];

endmodule

`default_nettype wire

// ==== rtl/systolic_gemm.sv ====
// Top level of the 4x4 systolic GEMM: controller, operand buffers, PE array, result store
`timescale 1ns/10ps
`default_nettype none

module systolic_gemm import gemm_pkg::*; (
    input  logic                 clk,
    input  logic                 rst_n,
    input  operand_wr_t          a_wr,
    input  operand_wr_t          b_wr,
    input  logic                 start,
    output logic                 busy,
    output logic                 done,
    input  logic [IDX_WIDTH-1:0] rd_row,
    input  logic [IDX_WIDTH-1:0] rd_col,
    output acc_t                 rd_data
);

    logic       clear;
    logic       feed_en;
    logic [3:0] step;
    logic       capture;
    lane_feed_t a_feed;
    lane_feed_t b_feed;
    acc_grid_t  acc;

    gemm_ctrl u_ctrl (
        .clk     (clk),
        .rst_n   (rst_n),
        .start   (start),
        .busy    (busy),
        .done    (done),
        .clear   (clear),
        .feed_en (feed_en),
        .step    (step),
        .capture (capture)
    );

    // A lanes are rows, B lanes are columns
    operand_buffer u_buf_a (
        .clk     (clk),
        .rst_n   (rst_n),
        .wr      (a_wr),
        .feed_en (feed_en),
        .step    (step),
        .feed    (a_feed)
    );

    operand_buffer u_buf_b (
        .clk     (clk),
        .rst_n   (rst_n),
        .wr      (b_wr),
        .feed_en (feed_en),
        .step    (step),
        .feed    (b_feed)
    );

    pe_array u_array (
        .clk    (clk),
        .rst_n  (rst_n),
        .clear  (clear),
        .a_feed (a_feed),
        .b_feed (b_feed),
        .acc    (acc)
    );

    result_buffer u_result (
        .clk     (clk),
        .rst_n   (rst_n),
        .capture (capture),
        .acc     (acc),
        .rd_row  (rd_row),
        .rd_col  (rd_col),
        .rd_data (rd_data)
    );

endmodule

`default_nettype wire

// ==== test/tb_checker.sv ====
// Result and protocol monitor for the systolic GEMM testbench
`timescale 1ns/10ps
`default_nettype none

module tb_checker import gemm_pkg::*; (
    input  logic                 clk,
    input  logic                 busy,
    input  logic                 done,
    input  logic                 read_req,
    input  acc_grid_t            expected,
    input  logic [127:0]         test_name,
    input  acc_t                 rd_data,
    output logic [IDX_WIDTH-1:0] rd_row,
    output logic [IDX_WIDTH-1:0] rd_col,
    output int                   tests_passed,
    output int                   tests_failed,
    output int                   errors,
    output int                   done_count
);

    localparam int BUSY_CYCLES = 1 + STREAM_CYCLES + DRAIN_CYCLES + 1;

    int busy_len = 0;
    int run_dones = 0;
    int errors_seen = 0;
    acc_t held_val = '0;

    // First posedge after done is the capture edge
    task automatic read_and_compare;
        acc_t exp_val;
        for (int e = 0; e < ARRAY_SIZE * ARRAY_SIZE; e++) begin
            @(posedge clk);
            #2;
            rd_row = e[3:2];
            rd_col = e[1:0];
            @(negedge clk);
            exp_val = expected[e];
            if (rd_data !== exp_val) begin
                $display("FAIL %0s entry (%0d,%0d) expected %0d actual %0d",
                         test_name, e[3:2], e[1:0], exp_val, rd_data);
                errors++;
            end
        end
        // Read address stays on the last entry until the next read
        held_val = expected[ARRAY_SIZE*ARRAY_SIZE-1];
        if (errors == errors_seen) begin
            $display("test %0s ok", test_name);
            tests_passed++;
        end else begin
            $display("test %0s has %0d errors", test_name, errors - errors_seen);
            tests_failed++;
        end
        errors_seen = errors;
    endtask

    initial begin
        rd_row       = '0;
        rd_col       = '0;
        tests_passed = 0;
        tests_failed = 0;
        errors       = 0;
        done_count   = 0;
        forever begin
            @(negedge clk);
            if (done || read_req) begin
                if (read_req && (busy || done)) begin
                    $display("ERROR: busy or done is high while the DUT should be idle");
                    errors++;
                end
                read_and_compare();
            end
        end
    end

    // Busy length and done count per run
    always @(negedge clk) begin
        if (done) begin
            done_count++;
            run_dones++;
            if (!busy) begin
                $display("ERROR: done pulsed while busy was low");
                errors++;
            end
        end
        // Previous result holds until the capture edge at the end of DONE
        if (busy && rd_data !== held_val) begin
            $display("FAIL %0s hold entry (%0d,%0d) expected %0d actual %0d",
                     test_name, rd_row, rd_col, held_val, rd_data);
            errors++;
        end
        if (busy) begin
            busy_len++;
        end else if (busy_len != 0) begin
            if (busy_len != BUSY_CYCLES) begin
                $display("ERROR: busy stayed high for %0d cycles instead of %0d",
                         busy_len, BUSY_CYCLES);
                errors++;
            end
            if (run_dones != 1) begin
                $display("ERROR: done pulsed %0d times in one busy period", run_dones);
                errors++;
            end
            busy_len  = 0;
            run_dones = 0;
        end
    end

endmodule

`default_nettype wire

// ==== test/tb_clock.sv ====
// Testbench clock generator and power-on reset sequence
`timescale 1ns/10ps
`default_nettype none

module tb_clock (
    output logic clk,
    output logic rst_n
);

    localparam int PERIOD       = 20;
    localparam int RESET_CYCLES = 3;

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    // Release shortly after the last reset edge
    initial begin
        rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        #2;
        rst_n = 1'b1;
    end

endmodule

`default_nettype wire

// ==== test/tb_systolic_gemm.sv ====
// Testbench top: DUT, stimulus, LFSR operands, reference product and watchdog
`timescale 1ns/10ps
`default_nettype none

module tb_systolic_gemm import gemm_pkg::*; ();

    typedef operand_t [ARRAY_SIZE*ARRAY_SIZE-1:0] matrix_t;

    localparam int  NUM_RUNS    = 10;
    localparam int  RUN_CYCLES  = 64 + 14 + 20;
    localparam time WATCHDOG_NS = (NUM_RUNS + 1) * RUN_CYCLES * 20 + 2000;

    logic                 clk;
    logic                 rst_n;
    operand_wr_t          a_wr;
    operand_wr_t          b_wr;
    logic                 start;
    logic                 busy;
    logic                 done;
    logic [IDX_WIDTH-1:0] rd_row;
    logic [IDX_WIDTH-1:0] rd_col;
    acc_t                 rd_data;
    acc_grid_t            expected;
    logic [127:0]         test_name;
    logic                 read_req;
    logic [31:0]          lfsr;
    int                   tests_passed;
    int                   tests_failed;
    int                   errors;
    int                   done_count;
    int                   next_count;

    tb_clock u_clock (.clk(clk), .rst_n(rst_n));

    systolic_gemm u_systolic_gemm (
        .clk     (clk),
        .rst_n   (rst_n),
        .a_wr    (a_wr),
        .b_wr    (b_wr),
        .start   (start),
        .busy    (busy),
        .done    (done),
        .rd_row  (rd_row),
        .rd_col  (rd_col),
        .rd_data (rd_data)
    );

    tb_checker u_checker (
        .clk(clk), .busy(busy), .done(done), .read_req(read_req),
        .expected(expected), .test_name(test_name), .rd_data(rd_data),
        .rd_row(rd_row), .rd_col(rd_col), .tests_passed(tests_passed),
        .tests_failed(tests_failed), .errors(errors), .done_count(done_count)
    );

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    // C[i][j] = sum over k of A[i][k] * B[k][j], wrapping at 32 bits
    function automatic acc_grid_t gemm_ref(input matrix_t a, input matrix_t b);
        acc_grid_t c;
        acc_t      sum;
        operand_t  x;
        operand_t  y;
        for (int i = 0; i < ARRAY_SIZE; i++) begin
            for (int j = 0; j < ARRAY_SIZE; j++) begin
                sum = '0;
                for (int k = 0; k < ARRAY_SIZE; k++) begin
                    x   = a[i*ARRAY_SIZE + k];
                    y   = b[k*ARRAY_SIZE + j];
                    sum = sum + acc_t'(x) * acc_t'(y);
                end
                c[i*ARRAY_SIZE + j] = sum;
            end
        end
        return c;
    endfunction

    task automatic random_matrix(output matrix_t m);
        for (int e = 0; e < ARRAY_SIZE * ARRAY_SIZE; e++) begin
            for (int n = 0; n < DATA_WIDTH; n++) begin
                m[e][n] = lfsr[0];
                lfsr    = lfsr_next(lfsr);
            end
        end
    endtask

    // Entry e is A[e/4][e%4] and B[e/4][e%4]; B lanes are columns
    task automatic load_operands(input matrix_t a, input matrix_t b);
        for (int e = 0; e < ARRAY_SIZE * ARRAY_SIZE; e++) begin
            @(posedge clk);
            #2;
            a_wr.en   = 1'b1;
            a_wr.lane = e[3:2];
            a_wr.pos  = e[1:0];
            a_wr.data = a[e];
            b_wr.en   = 1'b1;
            b_wr.lane = e[1:0];
            b_wr.pos  = e[3:2];
            b_wr.data = b[e];
        end
        @(posedge clk);
        #2;
        a_wr.en = 1'b0;
        b_wr.en = 1'b0;
    endtask

    task automatic pulse_start;
        @(posedge clk);
        #2;
        start = 1'b1;
        @(posedge clk);
        #2;
        start = 1'b0;
    endtask

    task automatic start_run(input logic [127:0] name, input matrix_t a, input matrix_t b);
        test_name  = name;
        expected   = gemm_ref(a, b);
        next_count = tests_passed + tests_failed + 1;
        pulse_start();
    endtask

    task automatic wait_result;
        wait (tests_passed + tests_failed == next_count);
    endtask

    initial begin
        matrix_t a;
        matrix_t b;
        matrix_t b_new;
        a_wr      = '0;
        b_wr      = '0;
        start     = 1'b0;
        read_req  = 1'b0;
        expected  = '0;
        test_name = "reset";
        lfsr      = 32'h38df;
        next_count = 1;
        wait (rst_n);
        @(posedge clk);
        #2;
        read_req = 1'b1;
        @(posedge clk);
        #2;
        read_req = 1'b0;
        wait_result();

        for (int e = 0; e < ARRAY_SIZE * ARRAY_SIZE; e++) begin
            a[e] = (e[3:2] == e[1:0]) ? 16'sd1 : 16'sd0;
            b[e] = 16'(e * 3 - 20);
        end
        load_operands(a, b);
        start_run("identity", a, b);
        wait_result();
        for (int e = 0; e < ARRAY_SIZE * ARRAY_SIZE; e++) begin
            a[e] = 16'(e - 7);
            b[e] = 16'(11 - 2 * e);
        end
        load_operands(a, b);
        start_run("small_fixed", a, b);
        wait_result();
        // Four products of 2^30 wrap to zero
        a = {16{16'h8000}};
        b = a;
        load_operands(a, b);
        start_run("min_wrap", a, b);
        wait_result();
        for (int r = 0; r < 4; r++) begin
            random_matrix(a);
            random_matrix(b);
            load_operands(a, b);
            start_run("random", a, b);
            wait_result();
        end

        random_matrix(a);
        random_matrix(b);
        load_operands(a, b);
        start_run("busy_start", a, b);
        repeat (4) @(posedge clk);
        #2;
        start = 1'b1;
        @(posedge clk);
        #2;
        start = 1'b0;
        wait_result();

        // New B lands in DRAIN, after the last streaming read
        random_matrix(a);
        random_matrix(b);
        random_matrix(b_new);
        load_operands(a, b);
        start_run("overwrite_old", a, b);
        repeat (10) @(posedge clk);
        load_operands(a, b_new);
        wait_result();
        start_run("overwrite_new", a, b_new);
        wait_result();
        repeat (4) @(posedge clk);

        if (done_count != NUM_RUNS) begin
            $display("done pulsed %0d times over the run, expected %0d", done_count, NUM_RUNS);
        end
        $display("tests passed %0d, tests failed %0d, errors %0d",
                 tests_passed, tests_failed, errors);
        if (tests_failed == 0 && errors == 0 && done_count == NUM_RUNS) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Timeout at %0t, the DUT did not complete all runs", $time);
        $display("STATUS: FAIL");
        $finish;
    end

endmodule

`default_nettype wire
